// ==== patch_cfg.svh ====
`ifndef PATCH_CFG_SVH
`define PATCH_CFG_SVH

// patch geometry
`define PATCH_SIZE 8

// datapath widths
`define PIX_W 8
`define WGT_W 8
`define ROW_W 10
`define COL_W 10
`define SUM_W 24

// multiplier pipeline depth, lane request to pair sum
`define MAC_LAT 2

// register map, byte offsets
`define ADDR_CTRL     8'h00
`define ADDR_STATUS   8'h04
`define ADDR_ROW      8'h08
`define ADDR_COL      8'h0C
`define ADDR_RESULT   8'h10
`define ADDR_WGT_BASE 8'h20

`endif

// ==== patch_pkg.sv ====
`default_nettype none

`include "patch_cfg.svh"

package patch_pkg;

  localparam int PIDX_W = $clog2(`PATCH_SIZE) + 1;

  typedef logic [`PIX_W-1:0] pix_t;
  typedef logic signed [`WGT_W-1:0] wgt_t;
  // one extra bit for the zero-extended pixel
  typedef logic signed [`PIX_W+`WGT_W:0] prod_t;
  typedef logic signed [`SUM_W-1:0] sum_t;
  typedef logic [`ROW_W-1:0] row_t;
  typedef logic [`COL_W-1:0] col_t;
  typedef logic [PIDX_W-1:0] pidx_t;

  // two pixels per beat, col is always even
  typedef struct packed {
    logic valid;
    row_t row;
    col_t col;
    pix_t p0;
    pix_t p1;
  } pix_beat_t;

  typedef struct packed {
    row_t row;
    col_t col;
  } patch_cfg_t;

  // widx is the weight position of lane 0
  typedef struct packed {
    logic  en0;
    logic  en1;
    pidx_t widx;
  } lane_req_t;

  typedef enum logic [2:0] {
    IDLE,
    MATCH_WAIT,
    MATCHED,
    SUM_WAIT,
    SUM_RDY
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== apb_pkg.sv ====
`default_nettype none

package apb_pkg;

  typedef logic [7:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // master side of an APB3 port
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // slave side
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// ==== patch_apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "patch_cfg.svh"

module patch_apb_regs (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire apb_pkg::apb_req_t     apb_req,
  input  wire logic                  busy,
  input  wire logic                  result_valid,
  input  wire patch_pkg::sum_t       result,
  output apb_pkg::apb_rsp_t          apb_rsp,
  output patch_pkg::patch_cfg_t      cfg,
  output logic                       start,
  output logic                       wgt_we,
  output patch_pkg::pidx_t           wgt_idx,
  output patch_pkg::wgt_t            wgt_data
);

  localparam int PS = `PATCH_SIZE;
  localparam int IW = $clog2(`PATCH_SIZE);
  localparam apb_pkg::apb_addr_t WGT_END =
    apb_pkg::apb_addr_t'(`ADDR_WGT_BASE + 4 * `PATCH_SIZE);

  logic access;
  logic wr;
  logic hit_ctrl;
  logic hit_status;
  logic hit_row;
  logic hit_col;
  logic hit_result;
  logic hit_wgt;
  logic blocked;
  patch_pkg::pidx_t idx;
  logic done_q;
  patch_pkg::sum_t result_q;
  // readback copy, the bank ports are taken by the datapath
  patch_pkg::wgt_t wgt_shadow [PS];

  // zero-wait access phase
  assign access = apb_req.psel & apb_req.penable;
  assign wr     = access & apb_req.pwrite;

  assign hit_ctrl   = apb_req.paddr == `ADDR_CTRL;
  assign hit_status = apb_req.paddr == `ADDR_STATUS;
  assign hit_row    = apb_req.paddr == `ADDR_ROW;
  assign hit_col    = apb_req.paddr == `ADDR_COL;
  assign hit_result = apb_req.paddr == `ADDR_RESULT;
  assign hit_wgt    = apb_req.paddr >= `ADDR_WGT_BASE && apb_req.paddr < WGT_END &&
                      apb_req.paddr[1:0] == 2'b00;
  assign idx = patch_pkg::pidx_t'((apb_req.paddr - `ADDR_WGT_BASE) >> 2);

  // search setup is frozen while a search runs
  assign blocked = busy & (hit_row | hit_col | hit_wgt);

  assign start    = wr & hit_ctrl & apb_req.pwdata[0] & ~busy;
  assign wgt_we   = wr & hit_wgt & ~busy;
  assign wgt_idx  = idx;
  assign wgt_data = apb_req.pwdata[`WGT_W-1:0];

  always_comb begin
    apb_rsp = '0;
    apb_rsp.pready = 1'b1;
    apb_rsp.pslverr = access & (~(hit_ctrl | hit_status | hit_row | hit_col |
                                  hit_result | hit_wgt) | (apb_req.pwrite & blocked));
    if (hit_status) begin
      apb_rsp.prdata = {30'd0, done_q, busy};
    end else if (hit_row) begin
      apb_rsp.prdata = 32'(cfg.row);
    end else if (hit_col) begin
      apb_rsp.prdata = 32'(cfg.col);
    end else if (hit_result) begin
      apb_rsp.prdata = 32'(result_q);
    end else if (hit_wgt) begin
      apb_rsp.prdata = 32'(wgt_shadow[idx[IW-1:0]]);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cfg      <= '0;
      done_q   <= 1'b0;
      result_q <= '0;
      for (int i = 0; i < PS; i++) begin
        wgt_shadow[i] <= '0;
      end
    end else begin
      if (wr & ~busy) begin
        if (hit_row) cfg.row <= apb_req.pwdata[`ROW_W-1:0];
        if (hit_col) cfg.col <= apb_req.pwdata[`COL_W-1:0];
        if (hit_wgt) wgt_shadow[idx[IW-1:0]] <= wgt_data;
      end
      // done is sticky until the next start
      if (start) done_q <= 1'b0;
      if (result_valid) begin
        done_q   <= 1'b1;
        result_q <= result;
      end
    end
  end

endmodule

`default_nettype wire

// ==== patch_weight_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "patch_cfg.svh"

module patch_weight_bank (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             we,
  input  wire patch_pkg::pidx_t widx,
  input  wire patch_pkg::wgt_t  wdata,
  input  wire patch_pkg::pidx_t ridx,
  output patch_pkg::wgt_t       w0,
  output patch_pkg::wgt_t       w1
);

  localparam int PS = `PATCH_SIZE;
  localparam int IW = $clog2(`PATCH_SIZE);

  patch_pkg::wgt_t wgt_q [PS];
  patch_pkg::pidx_t ridx1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < PS; i++) begin
        wgt_q[i] <= '0;
      end
    end else if (we && widx < PS) begin
      wgt_q[widx[IW-1:0]] <= wdata;
    end
  end

  // wraps to 0 when lane 0 sits just before the patch
  assign ridx1 = ridx + 1'b1;

  // positions past the end weigh zero
  assign w0 = (ridx < PS) ? wgt_q[ridx[IW-1:0]] : '0;
  assign w1 = (ridx1 < PS) ? wgt_q[ridx1[IW-1:0]] : '0;

endmodule

`default_nettype wire

// ==== pixel_pair_mac.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "patch_cfg.svh"

module pixel_pair_mac (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire patch_pkg::lane_req_t lanes,
  input  wire patch_pkg::pix_t      p0,
  input  wire patch_pkg::pix_t      p1,
  input  wire patch_pkg::wgt_t      w0,
  input  wire patch_pkg::wgt_t      w1,
  output patch_pkg::sum_t           pair_sum,
  output logic                      pair_valid
);

  // one multiply stage, the rest is the adder and delay
  localparam int N_ADD = `MAC_LAT - 1;

  patch_pkg::prod_t prod0_d;
  patch_pkg::prod_t prod1_d;
  patch_pkg::prod_t prod0_q;
  patch_pkg::prod_t prod1_q;
  logic mul_vld_q;
  patch_pkg::sum_t sum_q [N_ADD];
  logic [N_ADD-1:0] sum_vld_q;

  // disabled lane contributes zero
  always_comb begin
    prod0_d = '0;
    prod1_d = '0;
    if (lanes.en0) prod0_d = $signed({1'b0, p0}) * w0;
    if (lanes.en1) prod1_d = $signed({1'b0, p1}) * w1;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mul_vld_q <= 1'b0;
      sum_vld_q <= '0;
    end else begin
      mul_vld_q    <= lanes.en0 | lanes.en1;
      sum_vld_q[0] <= mul_vld_q;
      for (int k = 1; k < N_ADD; k++) begin
        sum_vld_q[k] <= sum_vld_q[k-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    prod0_q  <= prod0_d;
    prod1_q  <= prod1_d;
    sum_q[0] <= patch_pkg::sum_t'(prod0_q) + patch_pkg::sum_t'(prod1_q);
    for (int k = 1; k < N_ADD; k++) begin
      sum_q[k] <= sum_q[k-1];
    end
  end

  assign pair_sum   = sum_q[N_ADD-1];
  assign pair_valid = sum_vld_q[N_ADD-1];

endmodule

`default_nettype wire

// ==== patch_sum_accum.sv ====
`timescale 1ns/1ns
`default_nettype none

module patch_sum_accum (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             clear,
  input  wire patch_pkg::sum_t  pair_sum,
  input  wire logic             pair_valid,
  output patch_pkg::sum_t       acc,
  output patch_pkg::pidx_t      n_pairs
);

  patch_pkg::sum_t acc_q;
  patch_pkg::pidx_t n_pairs_q;

  // clear wins, nothing is in flight when a search starts
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc_q     <= '0;
      n_pairs_q <= '0;
    end else if (clear) begin
      acc_q     <= '0;
      n_pairs_q <= '0;
    end else if (pair_valid) begin
      acc_q     <= acc_q + pair_sum;
      n_pairs_q <= n_pairs_q + 1'b1;
    end
  end

  // count lets the control see when the last issued pair landed
  assign acc     = acc_q;
  assign n_pairs = n_pairs_q;

endmodule

`default_nettype wire

// ==== patch_row_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "patch_cfg.svh"

module patch_row_ctrl (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  start,
  input  wire patch_pkg::patch_cfg_t cfg,
  input  wire patch_pkg::pix_beat_t  beat,
  input  wire patch_pkg::sum_t       acc,
  input  wire patch_pkg::pidx_t      n_pairs,
  output patch_pkg::lane_req_t       lanes,
  output patch_pkg::pix_t            p0,
  output patch_pkg::pix_t            p1,
  output logic                       acc_clear,
  output logic                       busy,
  output logic                       result_valid,
  output patch_pkg::sum_t            result
);

  localparam int PS = `PATCH_SIZE;

  patch_pkg::ctrl_state_e state_q;
  patch_pkg::col_t first_col;
  patch_pkg::col_t next_col_q;
  patch_pkg::pidx_t n_pix_q;
  patch_pkg::pidx_t n_pix_d;
  patch_pkg::pidx_t n_issued_q;
  patch_pkg::pidx_t remain;
  patch_pkg::pidx_t n_take;
  patch_pkg::lane_req_t lanes_d;
  logic accept_start;
  logic first_hit;
  logic next_hit;
  logic take;

  assign accept_start = start &&
                        (state_q == patch_pkg::IDLE || state_q == patch_pkg::SUM_RDY);
  assign acc_clear = accept_start;

  // beat holding the start column
  assign first_col = {cfg.col[`COL_W-1:1], 1'b0};
  assign first_hit = state_q == patch_pkg::MATCH_WAIT && beat.valid &&
                     beat.row == cfg.row && beat.col == first_col;
  // only the beat that continues the run counts
  assign next_hit  = state_q == patch_pkg::MATCHED && beat.valid &&
                     beat.row == cfg.row && beat.col == next_col_q;
  assign take   = first_hit | next_hit;
  assign remain = patch_pkg::pidx_t'(PS) - n_pix_q;

  always_comb begin
    lanes_d = '0;
    n_take  = '0;
    if (first_hit) begin
      lanes_d.en1 = 1'b1;
      if (cfg.col[0]) begin
        // odd start, p1 takes weight 0
        lanes_d.widx = '1;
        n_take = 1;
      end else begin
        lanes_d.en0 = 1'b1;
        n_take = 2;
      end
    end else if (next_hit) begin
      lanes_d.en0  = 1'b1;
      lanes_d.widx = n_pix_q;
      if (remain >= 2) begin
        lanes_d.en1 = 1'b1;
        n_take = 2;
      end else begin
        n_take = 1;
      end
    end
  end

  assign n_pix_d = n_pix_q + n_take;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q    <= patch_pkg::IDLE;
      lanes      <= '0;
      n_pix_q    <= '0;
      n_issued_q <= '0;
      next_col_q <= '0;
    end else begin
      lanes <= lanes_d;
      if (accept_start) begin
        n_pix_q    <= '0;
        n_issued_q <= '0;
      end else if (take) begin
        n_pix_q    <= n_pix_d;
        n_issued_q <= n_issued_q + 1'b1;
        next_col_q <= beat.col + patch_pkg::col_t'(2);
      end
      case (state_q)
        patch_pkg::IDLE:
          if (accept_start) state_q <= patch_pkg::MATCH_WAIT;
        patch_pkg::MATCH_WAIT, patch_pkg::MATCHED:
          if (take) state_q <= (n_pix_d >= PS) ? patch_pkg::SUM_WAIT : patch_pkg::MATCHED;
        // drain until every issued pair is in the sum
        patch_pkg::SUM_WAIT:
          if (n_pairs == n_issued_q) state_q <= patch_pkg::SUM_RDY;
        patch_pkg::SUM_RDY:
          state_q <= accept_start ? patch_pkg::MATCH_WAIT : patch_pkg::IDLE;
        default:
          state_q <= patch_pkg::IDLE;
      endcase
    end
  end

  // pixel pair lines up with lanes
  always_ff @(posedge clk) begin
    p0 <= beat.p0;
    p1 <= beat.p1;
  end

  assign busy = state_q == patch_pkg::MATCH_WAIT || state_q == patch_pkg::MATCHED ||
                state_q == patch_pkg::SUM_WAIT;
  assign result_valid = state_q == patch_pkg::SUM_RDY;
  assign result = acc;

endmodule

`default_nettype wire

// ==== patch_row_reducer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module patch_row_reducer_top (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire apb_pkg::apb_req_t    apb_req,
  input  wire patch_pkg::pix_beat_t beat,
  output apb_pkg::apb_rsp_t         apb_rsp,
  output logic                      done_irq
);

  patch_pkg::patch_cfg_t cfg;
  logic start;
  logic wgt_we;
  patch_pkg::pidx_t wgt_idx;
  patch_pkg::wgt_t wgt_data;
  logic busy;
  logic result_valid;
  patch_pkg::sum_t result;
  patch_pkg::lane_req_t lanes;
  patch_pkg::pix_t p0;
  patch_pkg::pix_t p1;
  patch_pkg::wgt_t w0;
  patch_pkg::wgt_t w1;
  patch_pkg::sum_t pair_sum;
  logic pair_valid;
  patch_pkg::sum_t acc;
  patch_pkg::pidx_t n_pairs;
  logic acc_clear;

  patch_apb_regs u_regs (
    .clk          (clk),
    .reset        (reset),
    .apb_req      (apb_req),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result),
    .apb_rsp      (apb_rsp),
    .cfg          (cfg),
    .start        (start),
    .wgt_we       (wgt_we),
    .wgt_idx      (wgt_idx),
    .wgt_data     (wgt_data)
  );

  patch_row_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .cfg          (cfg),
    .beat         (beat),
    .acc          (acc),
    .n_pairs      (n_pairs),
    .lanes        (lanes),
    .p0           (p0),
    .p1           (p1),
    .acc_clear    (acc_clear),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result)
  );

  // weights are read at lane 0's position and the one after
  patch_weight_bank u_wbank (
    .clk   (clk),
    .reset (reset),
    .we    (wgt_we),
    .widx  (wgt_idx),
    .wdata (wgt_data),
    .ridx  (lanes.widx),
    .w0    (w0),
    .w1    (w1)
  );

  pixel_pair_mac u_mac (
    .clk        (clk),
    .reset      (reset),
    .lanes      (lanes),
    .p0         (p0),
    .p1         (p1),
    .w0         (w0),
    .w1         (w1),
    .pair_sum   (pair_sum),
    .pair_valid (pair_valid)
  );

  patch_sum_accum u_accum (
    .clk        (clk),
    .reset      (reset),
    .clear      (acc_clear),
    .pair_sum   (pair_sum),
    .pair_valid (pair_valid),
    .acc        (acc),
    .n_pairs    (n_pairs)
  );

  assign done_irq = result_valid;

endmodule

`default_nettype wire

// ==== tb_patch_row_reducer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "patch_cfg.svh"

module tb_patch_row_reducer;

  localparam int PS = `PATCH_SIZE;
  localparam int NROWS = 6;
  localparam int NCOLS = 32;
  localparam int N_TESTS = 25;
  localparam int CLK_NS = 40;
  localparam int WATCHDOG_NS = N_TESTS * NROWS * NCOLS * CLK_NS * 2;

  logic clk;
  logic reset;
  apb_pkg::apb_req_t apb_req;
  apb_pkg::apb_rsp_t apb_rsp;
  patch_pkg::pix_beat_t beat;
  logic done_irq;

  int cyc = 0;
  int irq_total = 0;
  int irq_cyc = 0;
  int last_take_cyc;
  int wgt [PS];
  int row_pix [NCOLS];

  patch_row_reducer_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .apb_req  (apb_req),
    .beat     (beat),
    .apb_rsp  (apb_rsp),
    .done_irq (done_irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // rising edges since time zero
  always @(posedge clk) cyc <= cyc + 1;

  // done_irq sampled mid-cycle
  always @(negedge clk) begin
    if (done_irq) begin
      irq_cyc = cyc;
      irq_total = irq_total + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the searches did not finish within %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // setup phase, then zero-wait access phase
  task automatic apb_access(input logic wr, input apb_pkg::apb_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = wr;
    apb_req.paddr = addr;
    apb_req.pwdata = wdata;
    @(posedge clk);
    #5;
    apb_req.penable = 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    check("apb pready", 32'h1, 32'(apb_rsp.pready));
    @(posedge clk);
    #5;
    apb_req = '0;
  endtask

  task automatic apb_write(input apb_pkg::apb_addr_t addr, input logic [31:0] wdata,
                           output logic err);
    logic [31:0] rdata;
    apb_access(1'b1, addr, wdata, rdata, err);
  endtask

  task automatic apb_read(input apb_pkg::apb_addr_t addr, output logic [31:0] rdata,
                          output logic err);
    apb_access(1'b0, addr, 32'h0, rdata, err);
  endtask

  function automatic apb_pkg::apb_addr_t wgt_addr(input int i);
    return apb_pkg::apb_addr_t'(`ADDR_WGT_BASE + 4 * i);
  endfunction

  task automatic check_registers();
    logic [31:0] rdata;
    logic err;
    int val;
    apb_pkg::apb_addr_t bad [4];
    bad = '{8'h14, 8'h18, 8'h22, 8'h40};
    apb_read(`ADDR_STATUS, rdata, err);
    check("reset status", 32'h0, rdata);
    check("status read pslverr", 32'h0, 32'(err));
    apb_read(`ADDR_ROW, rdata, err);
    check("reset row", 32'h0, rdata);
    apb_read(`ADDR_COL, rdata, err);
    check("reset col", 32'h0, rdata);
    apb_read(`ADDR_RESULT, rdata, err);
    check("reset result", 32'h0, rdata);
    for (int i = 0; i < PS; i++) begin
      apb_read(wgt_addr(i), rdata, err);
      check($sformatf("reset weight %0d", i), 32'h0, rdata);
    end
    val = int'($urandom_range(0, 1023));
    apb_write(`ADDR_ROW, 32'(val), err);
    apb_read(`ADDR_ROW, rdata, err);
    check("row readback", 32'(val), rdata);
    val = int'($urandom_range(0, 1023));
    apb_write(`ADDR_COL, 32'(val), err);
    apb_read(`ADDR_COL, rdata, err);
    check("col readback", 32'(val), rdata);
    for (int i = 0; i < PS; i++) begin
      val = int'($urandom_range(0, 255)) - 128;
      apb_write(wgt_addr(i), 32'(val), err);
      apb_read(wgt_addr(i), rdata, err);
      check($sformatf("weight %0d readback", i), 32'(val), rdata);
    end
    for (int i = 0; i < 4; i++) begin
      apb_read(bad[i], rdata, err);
      check($sformatf("unmapped read %0h pslverr", bad[i]), 32'h1, 32'(err));
      apb_write(bad[i], 32'h0, err);
      check($sformatf("unmapped write %0h pslverr", bad[i]), 32'h1, 32'(err));
    end
  endtask

  // whole raster, two pixels per beat, optional gaps and stray beats
  task automatic stream_raster(input int target_row, input int start_col, input bit gaps);
    int last_col;
    int kind;
    last_col = (start_col + PS - 1) & ~1;
    for (int r = 0; r < NROWS; r++) begin
      for (int c = 0; c < NCOLS; c += 2) begin
        kind = gaps ? int'($urandom_range(0, 7)) : 7;
        while (kind < 3) begin
          beat.valid = (kind == 2);
          if (kind == 2) begin
            // stray rows lie outside the raster
            beat.row = patch_pkg::row_t'(NROWS + $urandom_range(0, 7));
            beat.col = patch_pkg::col_t'(2 * $urandom_range(0, NCOLS / 2 - 1));
          end else begin
            // idle beat that would hit the target row if valid were ignored
            beat.row = patch_pkg::row_t'(target_row);
            beat.col = patch_pkg::col_t'(c);
          end
          beat.p0 = patch_pkg::pix_t'($urandom_range(0, 255));
          beat.p1 = patch_pkg::pix_t'($urandom_range(0, 255));
          @(posedge clk);
          #5;
          kind = int'($urandom_range(0, 7));
        end
        beat.valid = 1'b1;
        beat.row = patch_pkg::row_t'(r);
        beat.col = patch_pkg::col_t'(c);
        beat.p0 = patch_pkg::pix_t'($urandom_range(0, 255));
        beat.p1 = patch_pkg::pix_t'($urandom_range(0, 255));
        if (r == target_row) begin
          row_pix[c] = int'(beat.p0);
          row_pix[c + 1] = int'(beat.p1);
          // sampled on the coming edge
          if (c == last_col) last_take_cyc = cyc + 1;
        end
        @(posedge clk);
        #5;
      end
    end
    beat = '0;
  endtask

  task automatic run_search(input string name, input int target_row, input int start_col,
                            input bit gaps, input bit busy_write);
    logic [31:0] rdata;
    logic err;
    int exp_sum;
    int irq_base;
    for (int i = 0; i < PS; i++) begin
      wgt[i] = int'($urandom_range(0, 255)) - 128;
      apb_write(wgt_addr(i), 32'(wgt[i]), err);
      check({name, " weight pslverr"}, 32'h0, 32'(err));
    end
    apb_write(`ADDR_ROW, 32'(target_row), err);
    apb_write(`ADDR_COL, 32'(start_col), err);
    check({name, " col pslverr"}, 32'h0, 32'(err));
    irq_base = irq_total;
    last_take_cyc = -1;
    apb_write(`ADDR_CTRL, 32'h1, err);
    check({name, " start pslverr"}, 32'h0, 32'(err));
    apb_read(`ADDR_STATUS, rdata, err);
    check({name, " status while busy"}, 32'h1, rdata);
    if (busy_write) begin
      apb_write(wgt_addr(int'($urandom_range(0, PS - 1))), $urandom, err);
      check({name, " weight write while busy pslverr"}, 32'h1, 32'(err));
    end
    stream_raster(target_row, start_col, gaps);
    while (irq_total == irq_base) begin
      @(posedge clk);
      #5;
    end
    repeat (2) begin
      @(posedge clk);
      #5;
    end
    exp_sum = 0;
    for (int i = 0; i < PS; i++) begin
      exp_sum += row_pix[start_col + i] * wgt[i];
    end
    apb_read(`ADDR_RESULT, rdata, err);
    check({name, " result"}, 32'(exp_sum), rdata);
    apb_read(`ADDR_STATUS, rdata, err);
    check({name, " status after done"}, 32'h2, rdata);
    check({name, " done_irq pulses"}, 32'h1, 32'(irq_total - irq_base));
    check({name, " done_irq latency"}, 32'(last_take_cyc + `MAC_LAT + 2), 32'(irq_cyc));
  endtask

  initial begin
    void'($urandom(32'hcfab));
    reset = 1'b1;
    apb_req = '0;
    beat = '0;
    last_take_cyc = -1;
    repeat (2) @(posedge clk);
    #5;
    reset = 1'b0;
    check_registers();
    run_search("even start", int'($urandom_range(0, NROWS - 1)),
               2 * int'($urandom_range(0, (NCOLS - PS) / 2)), 1'b0, 1'b0);
    run_search("odd start", int'($urandom_range(0, NROWS - 1)),
               2 * int'($urandom_range(0, (NCOLS - PS) / 2 - 1)) + 1, 1'b0, 1'b0);
    run_search("gaps and wrong rows", NROWS - 1,
               int'($urandom_range(0, NCOLS - PS)), 1'b1, 1'b0);
    run_search("write while busy", int'($urandom_range(0, NROWS - 1)),
               int'($urandom_range(0, NCOLS - PS)), 1'b0, 1'b1);
    for (int t = 0; t < 20; t++) begin
      run_search($sformatf("random search %0d", t), int'($urandom_range(0, NROWS - 1)),
                 int'($urandom_range(0, NCOLS - PS)), 1'($urandom_range(0, 1)),
                 $urandom_range(0, 3) == 0);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
patch_pkg.sv
apb_pkg.sv
patch_apb_regs.sv
patch_weight_bank.sv
pixel_pair_mac.sv
patch_sum_accum.sv
patch_row_ctrl.sv
patch_row_reducer_top.sv
tb_patch_row_reducer.sv

// ==== run.sh ====
#!/bin/sh
# build and run the patch row reducer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_patch_row_reducer

# simulation output goes to the terminal through stderr, grep decides the status
./obj_dir/Vtb_patch_row_reducer | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null

echo "run.sh: simulation passed"
